//--- tlb_pkg.sv
package tlb_pkg;

    // Table geometry
    localparam int num_entries = 16;
    localparam int index_w     = 4;

    // Address field widths, 4 KB pages and 32-bit physical address
    localparam int vpn_w   = 20;
    localparam int vpn2_w  = 19;                   // VPN without the even/odd page bit
    localparam int asid_w  = 8;
    localparam int pfn_w   = 20;
    localparam int cache_w = 3;

    // Cache attribute forced for kseg1 and unmapped useg
    localparam logic [cache_w-1:0] cache_uncached = 3'd2;

    // Top three VPN bits of the kernel unmapped segments
    localparam logic [2:0] seg_kseg0 = 3'b100;
    localparam logic [2:0] seg_kseg1 = 3'b101;

    // Lookup or probe request
    typedef struct packed {
        logic [vpn_w-1:0]  vpn;
        logic [asid_w-1:0] asid;
    } tlb_req_t;

    // Associative part of an entry
    typedef struct packed {
        logic [vpn2_w-1:0] vpn2;
        logic [asid_w-1:0] asid;
        logic              g;                  // Global, ASID ignored on compare
    } tlb_tag_t;

    // One physical page of a pair
    typedef struct packed {
        logic [pfn_w-1:0]   pfn;
        logic [cache_w-1:0] cache;
        logic               dirty;
        logic               valid;
    } tlb_page_t;

    // One RAM word
    typedef struct packed {
        tlb_page_t page0;                      // Even page
        tlb_page_t page1;                      // Odd page
    } tlb_pair_t;

    // Full entry as written by tlbwi/tlbwr and returned by tlbr
    typedef struct packed {
        tlb_tag_t  tag;
        tlb_pair_t pair;
    } tlb_entry_t;

    // Translation result of the data port
    typedef struct packed {
        logic               hit;
        logic [pfn_w-1:0]   pfn;
        logic [cache_w-1:0] cache;
        logic               dirty;
        logic               valid;
    } tlb_lookup_t;

    // Registered segment decision for one request
    typedef struct packed {
        logic             unmapped;
        logic             uncached;
        logic             use_kseg0;           // Take cache bits from kseg0_cache
        logic [pfn_w-1:0] unmapped_pfn;
    } tlb_seg_t;

endpackage

//--- tlb_tag_cam.sv
`timescale 1ns/1ns

module tlb_tag_cam (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         write,
    input  logic [tlb_pkg::index_w-1:0]  index,
    input  tlb_pkg::tlb_tag_t            tag_in,
    output tlb_pkg::tlb_tag_t            tag_out,
    input  tlb_pkg::tlb_req_t            req,
    output logic                         match,
    output logic                         odd_page,
    output logic [tlb_pkg::index_w-1:0]  match_index
);

    tlb_pkg::tlb_tag_t tags [tlb_pkg::num_entries];

    logic [tlb_pkg::vpn2_w-1:0] req_vpn2;

    assign req_vpn2 = req.vpn[tlb_pkg::vpn_w-1:1];  // Page pair of the request
    assign tag_out  = tags[index];                  // Index read for tlbr

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < tlb_pkg::num_entries; i++) begin
                tags[i] <= '0;
            end
        end else if (write) begin
            tags[index] <= tag_in;
        end
    end

    // Associative compare, later entries override earlier ones
    always_comb begin
        match       = 1'b0;
        match_index = '0;
        odd_page    = 1'b0;
        for (int unsigned i = 0; i < tlb_pkg::num_entries; i++) begin
            if ((tags[i].vpn2 == req_vpn2) &&
                ((tags[i].asid == req.asid) || tags[i].g)) begin
                match       = 1'b1;
                match_index = i[tlb_pkg::index_w-1:0];
                odd_page    = req.vpn[0];           // Low VPN bit picks the odd page
            end
        end
    end

    // An undefined write index would corrupt an arbitrary entry
    a_write_index_known : assert property (
        @(posedge clock) disable iff (rst)
        write |-> !$isunknown(index)
    ) else $error("tag write with unknown index");

endmodule

//--- tlb_page_ram.sv
`timescale 1ns/1ns

module tlb_page_ram (
    input  logic                         clock,
    input  logic                         rst,
    input  logic [tlb_pkg::index_w-1:0]  addr,
    input  logic                         write,
    input  tlb_pkg::tlb_pair_t           din,
    output tlb_pkg::tlb_pair_t           dout
);

    tlb_pkg::tlb_pair_t mem [tlb_pkg::num_entries];

    // Single port, the read returns the word as it was before the write
    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < tlb_pkg::num_entries; i++) begin
                mem[i] <= '0;
            end
            dout <= '0;
        end else begin
            if (write) begin
                mem[addr] <= din;
            end
            dout <= mem[addr];                      // Registered read
        end
    end

endmodule

//--- tlb_segment_decode.sv
`timescale 1ns/1ns

module tlb_segment_decode (
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        hold,
    input  logic [tlb_pkg::vpn_w-1:0]   vpn,
    input  logic                        useg_mapped,
    output tlb_pkg::tlb_seg_t           seg
);

    logic              is_kseg0;
    logic              is_kseg1;
    logic              is_plain_useg;
    tlb_pkg::tlb_seg_t seg_next;

    assign is_kseg0      = (vpn[19:17] == tlb_pkg::seg_kseg0);
    assign is_kseg1      = (vpn[19:17] == tlb_pkg::seg_kseg1);
    assign is_plain_useg = !vpn[19] && !useg_mapped;    // useg bypassing the TLB

    always_comb begin
        seg_next.unmapped  = is_kseg0 || is_kseg1 || is_plain_useg;
        seg_next.uncached  = is_kseg1 || is_plain_useg;
        seg_next.use_kseg0 = is_kseg0;
        // kseg0/kseg1 fold onto the low 512 MB, useg passes through
        seg_next.unmapped_pfn = {1'b0,
                                 vpn[18] & ~vpn[19],
                                 vpn[17] & ~vpn[19],
                                 vpn[16:0]};
    end

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            seg <= '0;
        end else if (!hold) begin
            seg <= seg_next;                            // Frozen while stalled
        end
    end

endmodule

//--- tlb_hold_stage.sv
`timescale 1ns/1ns

module tlb_hold_stage (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          stall,
    input  logic [tlb_pkg::cache_w-1:0]   kseg0_cache,
    input  logic                          match,
    input  logic                          odd_page,
    input  logic [tlb_pkg::index_w-1:0]   match_index,
    input  tlb_pkg::tlb_tag_t             tag,
    input  tlb_pkg::tlb_pair_t            pair,
    input  tlb_pkg::tlb_seg_t             seg,
    output tlb_pkg::tlb_lookup_t          lookup_result,
    output logic [tlb_pkg::index_w-1:0]   probe_index,
    output tlb_pkg::tlb_entry_t           entry_out
);

    // Service stage registers, aligned with the RAM output
    logic                         match_q;
    logic                         odd_page_q;
    logic [tlb_pkg::index_w-1:0]  index_q;
    tlb_pkg::tlb_tag_t            tag_q;
    logic [tlb_pkg::cache_w-1:0]  kseg0_cache_q;

    logic                         hold_flag;        // Stall seen last cycle
    tlb_pkg::tlb_page_t           page;
    tlb_pkg::tlb_lookup_t         live_lookup;
    tlb_pkg::tlb_entry_t          live_entry;

    // Copies of the last unstalled outputs
    tlb_pkg::tlb_lookup_t         held_lookup;
    logic [tlb_pkg::index_w-1:0]  held_index;
    tlb_pkg::tlb_entry_t          held_entry;

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            match_q       <= 1'b0;
            odd_page_q    <= 1'b0;
            index_q       <= '0;
            tag_q         <= '0;
            kseg0_cache_q <= '0;
            hold_flag     <= 1'b0;
        end else begin
            match_q       <= match;
            odd_page_q    <= odd_page;
            index_q       <= match_index;
            tag_q         <= tag;
            kseg0_cache_q <= kseg0_cache;
            hold_flag     <= stall;
        end
    end

    assign page = odd_page_q ? pair.page1 : pair.page0;

    always_comb begin
        live_lookup.hit   = seg.unmapped || match_q;
        live_lookup.pfn   = seg.unmapped ? seg.unmapped_pfn : page.pfn;
        live_lookup.dirty = seg.unmapped || page.dirty;
        live_lookup.valid = seg.unmapped || page.valid;
        if (seg.uncached) begin
            live_lookup.cache = tlb_pkg::cache_uncached;
        end else if (seg.use_kseg0) begin
            live_lookup.cache = kseg0_cache_q;
        end else begin
            live_lookup.cache = page.cache;
        end
    end

    assign live_entry = '{tag: tag_q, pair: pair};

    always_ff @(posedge clock or posedge rst) begin
        if (rst) begin
            held_lookup <= '0;
            held_index  <= '0;
            held_entry  <= '0;
        end else if (!hold_flag) begin
            held_lookup <= live_lookup;
            held_index  <= index_q;
            held_entry  <= live_entry;
        end
    end

    assign lookup_result = hold_flag ? held_lookup : live_lookup;
    assign probe_index   = hold_flag ? held_index  : index_q;
    assign entry_out     = hold_flag ? held_entry  : live_entry;

    // A stalled cycle repeats the previous outputs on the next one
    a_stall_freeze : assert property (
        @(posedge clock) disable iff (rst)
        stall |=> $stable(lookup_result) && $stable(probe_index) && $stable(entry_out)
    ) else $error("outputs changed after a stall cycle");

endmodule

//--- tlb_16.sv
`timescale 1ns/1ns

module tlb_16 (
    input  logic                          clock,
    input  logic                          rst,
    input  tlb_pkg::tlb_req_t             lookup,        // Data access or tlbp request
    input  logic                          stall,
    input  logic                          cmd_read,      // tlbr
    input  logic                          cmd_write,     // tlbwi/tlbwr
    input  logic [tlb_pkg::index_w-1:0]   write_index,
    input  tlb_pkg::tlb_entry_t           write_entry,
    input  logic                          useg_mapped,
    input  logic [tlb_pkg::cache_w-1:0]   kseg0_cache,
    output tlb_pkg::tlb_lookup_t          lookup_result,
    output logic [tlb_pkg::index_w-1:0]   probe_index,
    output tlb_pkg::tlb_entry_t           entry_out
);

    logic                         cam_match;
    logic                         cam_odd_page;
    logic [tlb_pkg::index_w-1:0]  cam_match_index;
    tlb_pkg::tlb_tag_t            cam_tag;
    logic [tlb_pkg::index_w-1:0]  table_addr;
    tlb_pkg::tlb_pair_t           ram_dout;
    tlb_pkg::tlb_seg_t            seg;

    // Commands use the given index, lookups follow the CAM match
    assign table_addr = (cmd_read || cmd_write) ? write_index : cam_match_index;

    tlb_tag_cam u_cam (
        .clock       (clock),
        .rst         (rst),
        .write       (cmd_write),
        .index       (table_addr),
        .tag_in      (write_entry.tag),
        .tag_out     (cam_tag),
        .req         (lookup),
        .match       (cam_match),
        .odd_page    (cam_odd_page),
        .match_index (cam_match_index)
    );

    tlb_page_ram u_ram (
        .clock (clock),
        .rst   (rst),
        .addr  (table_addr),
        .write (cmd_write),
        .din   (write_entry.pair),
        .dout  (ram_dout)
    );

    tlb_segment_decode u_seg (
        .clock       (clock),
        .rst         (rst),
        .hold        (stall),
        .vpn         (lookup.vpn),
        .useg_mapped (useg_mapped),
        .seg         (seg)
    );

    tlb_hold_stage u_hold (
        .clock         (clock),
        .rst           (rst),
        .stall         (stall),
        .kseg0_cache   (kseg0_cache),
        .match         (cam_match),
        .odd_page      (cam_odd_page),
        .match_index   (cam_match_index),
        .tag           (cam_tag),
        .pair          (ram_dout),
        .seg           (seg),
        .lookup_result (lookup_result),
        .probe_index   (probe_index),
        .entry_out     (entry_out)
    );

    // Read and write share the one RAM port and the CAM index
    a_single_command : assert property (
        @(posedge clock) disable iff (rst)
        !(cmd_read && cmd_write)
    ) else $error("cmd_read and cmd_write high together");

endmodule

//--- tb_tlb_checker.sv
`timescale 1ns/1ns

module tb_tlb_checker (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          exp_valid,
    input  logic [127:0]                  exp_name,
    input  logic                          chk_lookup,
    input  logic                          chk_hit,
    input  logic                          chk_probe,
    input  logic                          chk_entry,
    input  tlb_pkg::tlb_lookup_t          exp_lookup,
    input  logic [tlb_pkg::index_w-1:0]   exp_probe,
    input  tlb_pkg::tlb_entry_t           exp_entry,
    input  tlb_pkg::tlb_lookup_t          lookup_result,
    input  logic [tlb_pkg::index_w-1:0]   probe_index,
    input  tlb_pkg::tlb_entry_t           entry_out,
    input  logic                          report,
    output int                            error_count
);

    // Expected values of the row applied last cycle
    logic                         pend_valid;
    logic [127:0]                 pend_name;
    logic [3:0]                   pend_chk;        // lookup, hit, probe, entry
    tlb_pkg::tlb_lookup_t         pend_lookup;
    logic [tlb_pkg::index_w-1:0]  pend_probe;
    tlb_pkg::tlb_entry_t          pend_entry;

    int checks        = 0;
    int lookup_errors = 0;
    int probe_errors  = 0;
    int entry_errors  = 0;

    assign error_count = lookup_errors + probe_errors + entry_errors;

    function automatic string name_text(input logic [127:0] bits);
        string s;
        byte   c;
        s = "";
        for (int i = 15; i >= 0; i--) begin
            c = bits[i*8 +: 8];
            if (c != 0) begin
                s = $sformatf("%s%c", s, c);
            end
        end
        return s;
    endfunction

    always @(posedge clock or posedge rst) begin
        if (rst) begin
            pend_valid <= 1'b0;
            pend_name  <= '0;
            pend_chk   <= '0;
            pend_lookup <= '0;
            pend_probe <= '0;
            pend_entry <= '0;
        end else begin
            pend_valid  <= exp_valid;
            pend_name   <= exp_name;
            pend_chk    <= {chk_lookup, chk_hit, chk_probe, chk_entry};
            pend_lookup <= exp_lookup;
            pend_probe  <= exp_probe;
            pend_entry  <= exp_entry;
        end
    end

    // Outputs are stable in the middle of the cycle
    always @(negedge clock) begin
        if (!rst && pend_valid) begin
            checks++;
            if (pend_chk[3] && lookup_result !== pend_lookup) begin
                lookup_errors++;
                $display("** Error %s: lookup_result expected %h actual %h at %0t",
                         name_text(pend_name), pend_lookup, lookup_result, $time);
            end
            if (pend_chk[2] && lookup_result.hit !== pend_lookup.hit) begin
                lookup_errors++;
                $display("** Error %s: hit expected %b actual %b at %0t",
                         name_text(pend_name), pend_lookup.hit, lookup_result.hit, $time);
            end
            if (pend_chk[1] && probe_index !== pend_probe) begin
                probe_errors++;
                $display("** Error %s: probe_index expected %0d actual %0d at %0t",
                         name_text(pend_name), pend_probe, probe_index, $time);
            end
            if (pend_chk[0] && entry_out !== pend_entry) begin
                entry_errors++;
                $display("** Error %s: entry_out expected %h actual %h at %0t",
                         name_text(pend_name), pend_entry, entry_out, $time);
            end
        end
    end

    always @(posedge report) begin
        $display("Checked %0d rows: lookup errors %0d, probe errors %0d, entry errors %0d",
                 checks, lookup_errors, probe_errors, entry_errors);
    end

endmodule

//--- tb_tlb_16.sv
`timescale 1ns/1ns

module tb_tlb_16;

    localparam int half_period  = 4;                // 8 ns clock
    localparam int reset_cycles = 16;
    localparam int name_w       = 128;              // Up to 16 characters of test name

    localparam logic [1:0] op_none  = 2'd0;
    localparam logic [1:0] op_write = 2'd1;
    localparam logic [1:0] op_read  = 2'd2;

    // One row of the stimulus table with the outputs expected one cycle later
    typedef struct packed {
        logic [name_w-1:0]                name;
        logic [1:0]                       op;
        logic                             stall;
        tlb_pkg::tlb_req_t                req;
        logic [tlb_pkg::index_w-1:0]      index;
        tlb_pkg::tlb_entry_t              entry;
        logic                             useg_mapped;
        logic [tlb_pkg::cache_w-1:0]      kseg0_cache;
        tlb_pkg::tlb_lookup_t             exp_lookup;
        logic [tlb_pkg::index_w-1:0]      exp_probe;
        tlb_pkg::tlb_entry_t              exp_entry;
        logic                             chk_lookup;
        logic                             chk_hit;      // Only the hit bit is defined
        logic                             chk_probe;
        logic                             chk_entry;
    } row_t;

    logic                          clock;
    logic                          rst;
    tlb_pkg::tlb_req_t             lookup;
    logic                          stall;
    logic                          cmd_read;
    logic                          cmd_write;
    logic [tlb_pkg::index_w-1:0]   write_index;
    tlb_pkg::tlb_entry_t           write_entry;
    logic                          useg_mapped;
    logic [tlb_pkg::cache_w-1:0]   kseg0_cache;
    tlb_pkg::tlb_lookup_t          lookup_result;
    logic [tlb_pkg::index_w-1:0]   probe_index;
    tlb_pkg::tlb_entry_t           entry_out;

    // Expected values handed to the checker
    logic                          exp_valid;
    logic [name_w-1:0]             exp_name;
    tlb_pkg::tlb_lookup_t          exp_lookup;
    logic [tlb_pkg::index_w-1:0]   exp_probe;
    tlb_pkg::tlb_entry_t           exp_entry;
    logic                          chk_lookup;
    logic                          chk_hit;
    logic                          chk_probe;
    logic                          chk_entry;
    logic                          report;
    int                            error_count;

    integer                        seed;
    row_t                          rows [$];
    tlb_pkg::tlb_entry_t           model [tlb_pkg::num_entries];   // Expected table contents
    int                            cycle_limit = 0;
    int                            cycle_count = 0;

    tlb_16 DUT (
        .clock         (clock),
        .rst           (rst),
        .lookup        (lookup),
        .stall         (stall),
        .cmd_read      (cmd_read),
        .cmd_write     (cmd_write),
        .write_index   (write_index),
        .write_entry   (write_entry),
        .useg_mapped   (useg_mapped),
        .kseg0_cache   (kseg0_cache),
        .lookup_result (lookup_result),
        .probe_index   (probe_index),
        .entry_out     (entry_out)
    );

    tb_tlb_checker u_checker (
        .clock         (clock),
        .rst           (rst),
        .exp_valid     (exp_valid),
        .exp_name      (exp_name),
        .chk_lookup    (chk_lookup),
        .chk_hit       (chk_hit),
        .chk_probe     (chk_probe),
        .chk_entry     (chk_entry),
        .exp_lookup    (exp_lookup),
        .exp_probe     (exp_probe),
        .exp_entry     (exp_entry),
        .lookup_result (lookup_result),
        .probe_index   (probe_index),
        .entry_out     (entry_out),
        .report        (report),
        .error_count   (error_count)
    );

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    function automatic logic [name_w-1:0] pack_name(input string s);
        logic [name_w-1:0] bits;
        bits = '0;
        for (int i = 0; i < s.len() && i < name_w / 8; i++) begin
            bits = {bits[name_w-9:0], s[i]};
        end
        return bits;
    endfunction

    function automatic tlb_pkg::tlb_page_t random_page();
        logic [31:0]        a;
        logic [31:0]        b;
        tlb_pkg::tlb_page_t p;
        a = $random(seed);
        b = $random(seed);
        p.pfn   = a[tlb_pkg::pfn_w-1:0];
        p.cache = b[2:0];
        p.dirty = b[3];
        p.valid = b[4];
        return p;
    endfunction

    // Odd entries sit in kseg2, even ones in useg
    function automatic logic [tlb_pkg::vpn2_w-1:0] pair_vpn2(input int i);
        logic [tlb_pkg::vpn2_w-1:0] base;
        base = i[0] ? 19'h60020 : 19'h00040;
        return base + i[tlb_pkg::vpn2_w-1:0];
    endfunction

    function automatic tlb_pkg::tlb_req_t req_for(input int i, input logic odd);
        tlb_pkg::tlb_req_t r;
        r.vpn  = {model[i].tag.vpn2, odd};
        r.asid = model[i].tag.asid;
        return r;
    endfunction

    task automatic add_write(input string name, input int i, input tlb_pkg::tlb_entry_t e);
        row_t r;
        r = '0;
        r.name        = pack_name(name);
        r.op          = op_write;
        r.index       = i[tlb_pkg::index_w-1:0];
        r.entry       = e;
        r.useg_mapped = 1'b1;
        r.kseg0_cache = 3'd3;
        model[i]      = e;                          // Visible to the next row
        rows.push_back(r);
    endtask

    task automatic add_read(input string name, input int i);
        row_t r;
        r = '0;
        r.name        = pack_name(name);
        r.op          = op_read;
        r.index       = i[tlb_pkg::index_w-1:0];
        r.useg_mapped = 1'b1;
        r.kseg0_cache = 3'd3;
        r.exp_entry   = model[i];
        r.chk_entry   = 1'b1;
        rows.push_back(r);
    endtask

    task automatic add_lookup(input string name, input tlb_pkg::tlb_req_t req,
                              input logic mapped_useg, input logic [2:0] k0_cache);
        row_t               r;
        logic [2:0]         seg_top;
        logic               unmapped;
        logic               found;
        int                 hit_idx;
        tlb_pkg::tlb_page_t pg;
        r = '0;
        r.name        = pack_name(name);
        r.op          = op_none;
        r.req         = req;
        r.useg_mapped = mapped_useg;
        r.kseg0_cache = k0_cache;
        seg_top  = req.vpn[19:17];
        unmapped = (seg_top == tlb_pkg::seg_kseg0) || (seg_top == tlb_pkg::seg_kseg1) ||
                   (!req.vpn[19] && !mapped_useg);
        if (unmapped) begin
            r.exp_lookup.hit   = 1'b1;
            r.exp_lookup.dirty = 1'b1;
            r.exp_lookup.valid = 1'b1;
            // Kernel segments map onto physical address zero
            r.exp_lookup.pfn   = req.vpn[19] ? {3'b000, req.vpn[16:0]} : req.vpn;
            r.exp_lookup.cache = (seg_top == tlb_pkg::seg_kseg0) ? k0_cache
                                                                 : tlb_pkg::cache_uncached;
            r.chk_lookup       = 1'b1;
        end else begin
            found   = 1'b0;
            hit_idx = 0;
            for (int i = tlb_pkg::num_entries - 1; i >= 0; i--) begin   // Highest index first
                if (!found && model[i].tag.vpn2 == req.vpn[tlb_pkg::vpn_w-1:1] &&
                    (model[i].tag.g || model[i].tag.asid == req.asid)) begin
                    found   = 1'b1;
                    hit_idx = i;
                end
            end
            if (found) begin
                pg = req.vpn[0] ? model[hit_idx].pair.page1 : model[hit_idx].pair.page0;
                r.exp_lookup.hit   = 1'b1;
                r.exp_lookup.pfn   = pg.pfn;
                r.exp_lookup.cache = pg.cache;
                r.exp_lookup.dirty = pg.dirty;
                r.exp_lookup.valid = pg.valid;
                r.exp_probe        = hit_idx[tlb_pkg::index_w-1:0];
                r.exp_entry        = model[hit_idx];
                r.chk_lookup       = 1'b1;
                r.chk_probe        = 1'b1;
                r.chk_entry        = 1'b1;
            end else begin
                r.chk_hit = 1'b1;                   // Miss, hit must be low
            end
        end
        rows.push_back(r);
    endtask

    // A stalled row repeats the outputs of the row before it
    task automatic add_stall(input string name, input tlb_pkg::tlb_req_t req);
        row_t r;
        r = rows[rows.size() - 1];
        r.name        = pack_name(name);
        r.op          = op_none;
        r.stall       = 1'b1;
        r.req         = req;
        r.index       = '0;
        r.entry       = '0;
        r.useg_mapped = 1'b1;
        r.kseg0_cache = 3'd3;
        rows.push_back(r);
    endtask

    task automatic build_table();
        tlb_pkg::tlb_entry_t e;
        tlb_pkg::tlb_req_t   r;
        logic [31:0]         rnd;
        for (int i = 0; i < tlb_pkg::num_entries; i++) begin
            model[i] = '0;                          // Reset contents
        end
        for (int i = 0; i < tlb_pkg::num_entries; i++) begin
            rnd          = $random(seed);
            e.tag.vpn2   = pair_vpn2(i);
            e.tag.asid   = rnd[7:0];
            e.tag.g      = (i == 5) || (i == 12);
            e.pair.page0 = random_page();
            e.pair.page1 = random_page();
            add_write($sformatf("write_e%0d", i), i, e);
        end
        for (int i = 0; i < tlb_pkg::num_entries; i++) begin
            add_read($sformatf("read_e%0d", i), i);
        end
        for (int i = 0; i < tlb_pkg::num_entries; i++) begin
            add_lookup($sformatf("map_even_e%0d", i), req_for(i, 1'b0), 1'b1, 3'd3);
        end
        for (int i = 1; i < tlb_pkg::num_entries; i += 4) begin
            add_lookup($sformatf("map_odd_e%0d", i), req_for(i, 1'b1), 1'b1, 3'd3);
        end
        r = req_for(5, 1'b1);
        r.asid = ~r.asid;                           // Foreign ASID on a global entry
        add_lookup("global_e5", r, 1'b1, 3'd3);
        r = req_for(12, 1'b0);
        r.asid = ~r.asid;
        add_lookup("global_e12", r, 1'b1, 3'd3);
        for (int i = 2; i < tlb_pkg::num_entries; i += 4) begin
            r = req_for(i, 1'b0);
            r.asid = r.asid ^ 8'h5a;
            add_lookup($sformatf("bad_asid_e%0d", i), r, 1'b1, 3'd3);
        end
        add_lookup("unwritten_useg", '{vpn: 20'h07000, asid: 8'h00}, 1'b1, 3'd3);
        add_lookup("unwritten_kseg3", '{vpn: 20'he1230, asid: 8'h11}, 1'b1, 3'd3);
        add_lookup("kseg0_cached", '{vpn: 20'h80123, asid: 8'h00}, 1'b1, 3'd3);
        add_lookup("kseg0_attr5", '{vpn: 20'h9abcd, asid: 8'h22}, 1'b1, 3'd5);
        add_lookup("kseg1_low", '{vpn: 20'ha1234, asid: 8'h00}, 1'b1, 3'd3);
        add_lookup("kseg1_top", '{vpn: 20'hbffff, asid: 8'h33}, 1'b1, 3'd7);
        add_lookup("useg_unmapped", req_for(4, 1'b0), 1'b0, 3'd3);
        add_lookup("useg_top", '{vpn: 20'h7ffff, asid: 8'h44}, 1'b0, 3'd3);
        add_lookup("probe_e15", req_for(15, 1'b1), 1'b1, 3'd3);
        add_lookup("probe_e0", req_for(0, 1'b0), 1'b1, 3'd3);
        add_lookup("probe_e7", req_for(7, 1'b1), 1'b1, 3'd3);
        add_lookup("probe_e9", req_for(9, 1'b0), 1'b1, 3'd3);
        add_lookup("pre_stall", req_for(3, 1'b0), 1'b1, 3'd3);
        add_stall("stall_1", req_for(4, 1'b1));
        add_stall("stall_2", req_for(6, 1'b0));
        add_stall("stall_3", '{vpn: 20'h80456, asid: 8'h00});
        add_lookup("post_stall", req_for(10, 1'b1), 1'b1, 3'd3);
        add_lookup("post_stall_2", req_for(11, 1'b0), 1'b1, 3'd3);
    endtask

    task automatic apply_row(input row_t r);
        lookup      = r.req;
        stall       = r.stall;
        cmd_write   = (r.op == op_write);
        cmd_read    = (r.op == op_read);
        write_index = r.index;
        write_entry = r.entry;
        useg_mapped = r.useg_mapped;
        kseg0_cache = r.kseg0_cache;
        exp_valid   = 1'b1;
        exp_name    = r.name;
        exp_lookup  = r.exp_lookup;
        exp_probe   = r.exp_probe;
        exp_entry   = r.exp_entry;
        chk_lookup  = r.chk_lookup;
        chk_hit     = r.chk_hit;
        chk_probe   = r.chk_probe;
        chk_entry   = r.chk_entry;
    endtask

    initial begin
        rst         = 1'b1;
        lookup      = '0;
        stall       = 1'b0;
        cmd_read    = 1'b0;
        cmd_write   = 1'b0;
        write_index = '0;
        write_entry = '0;
        useg_mapped = 1'b1;
        kseg0_cache = 3'd3;
        exp_valid   = 1'b0;
        exp_name    = '0;
        exp_lookup  = '0;
        exp_probe   = '0;
        exp_entry   = '0;
        chk_lookup  = 1'b0;
        chk_hit     = 1'b0;
        chk_probe   = 1'b0;
        chk_entry   = 1'b0;
        report      = 1'b0;
        seed        = 66;
        build_table();
        cycle_limit = rows.size() * 2 + reset_cycles + 100;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        for (int n = 0; n < rows.size(); n++) begin
            @(negedge clock);
            apply_row(rows[n]);
        end
        @(negedge clock);                           // Last row is checked here
        exp_valid = 1'b0;
        stall     = 1'b0;
        cmd_read  = 1'b0;
        cmd_write = 1'b0;
        repeat (2) @(negedge clock);
        report = 1'b1;                              // Checker prints its counts
        @(negedge clock);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- flist.f
tlb_pkg.sv
tlb_tag_cam.sv
tlb_page_ram.sv
tlb_segment_decode.sv
tlb_hold_stage.sv
tlb_16.sv
tb_tlb_checker.sv
tb_tlb_16.sv

//--- Makefile
# Verilator flow for the 16-entry TLB

VERILATOR ?= verilator
FLIST     ?= flist.f
RTL_TOP   ?= tlb_16
TB_TOP    ?= tb_tlb_16
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation gave no result, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
